//--- include/mips_params.svh
`ifndef MIPS_PARAMS_SVH
`define MIPS_PARAMS_SVH

// fetch address after reset, kseg1 boot rom
`define MIPS_RESET_VECTOR 32'hbfc0_0000

// jumping here stops the core
`define MIPS_HALT_ADDR 32'h0000_0000

// register indices
`define MIPS_REG_V0 5'd2   // result reg, exported at the top
`define MIPS_REG_RA 5'd31  // return address

`endif

//--- logic/mips_pkg.sv
package mips_pkg;

  // primary opcode, instr[31:26]
  typedef enum logic [5:0] {
    OP_SPECIAL = 6'h00,  // r-type, see funct
    OP_J       = 6'h02,
    OP_BEQ     = 6'h04,
    OP_BNE     = 6'h05,
    OP_ADDIU   = 6'h09,
    OP_ANDI    = 6'h0c,
    OP_ORI     = 6'h0d,
    OP_LUI     = 6'h0f,
    OP_LB      = 6'h20,
    OP_LW      = 6'h23,
    OP_LBU     = 6'h24,
    OP_SW      = 6'h2b
  } opcode_e;

  // special function field, instr[5:0]
  typedef enum logic [5:0] {
    FN_JR   = 6'h08,
    FN_ADDU = 6'h21,
    FN_SUBU = 6'h23,
    FN_AND  = 6'h24,
    FN_OR   = 6'h25,
    FN_XOR  = 6'h26,
    FN_SLT  = 6'h2a,
    FN_SLTU = 6'h2b
  } funct_e;

  // alu function select
  typedef enum logic [3:0] {
    ALU_ADD,
    ALU_SUB,
    ALU_AND,
    ALU_OR,
    ALU_XOR,
    ALU_SLT,   // signed compare
    ALU_SLTU,  // unsigned compare
    ALU_LUI    // imm into upper half
  } alu_op_e;

  // how the loaded word gets shaped
  typedef enum logic [1:0] {
    LD_WORD,
    LD_BYTE,    // sign extended
    LD_BYTE_U   // zero extended
  } load_kind_e;

endpackage

//--- logic/mips_ctrl_if.sv
`timescale 1ns/1ps

// decoded control for one instruction
interface mips_ctrl_if;
  import mips_pkg::*;

  alu_op_e    alu_op;
  logic       alu_src_imm;   // b operand from immediate
  logic       imm_zero_ext;  // andi/ori
  logic       reg_dst_rd;    // dest is rd, else rt
  logic       reg_write;
  logic       mem_to_reg;    // writeback takes load data
  logic       mem_write;
  logic       mem_read;
  load_kind_e load_kind;
  logic       branch_eq;
  logic       branch_ne;
  logic       jump;          // j target
  logic       jump_reg;      // jr

  modport decode (output alu_op, alu_src_imm, imm_zero_ext, reg_dst_rd, reg_write,
                  mem_to_reg, mem_write, mem_read, load_kind, branch_eq, branch_ne,
                  jump, jump_reg);
  modport execute (input alu_op, alu_src_imm, imm_zero_ext, reg_dst_rd, reg_write,
                   mem_write, mem_read, branch_eq, branch_ne, jump, jump_reg);
  modport result (input mem_to_reg, load_kind);
endinterface

// writeback path between execute and result
interface mips_wb_if;
  logic [31:0] alu_result;     // also the data address
  logic [31:0] data_readdata;  // from data bus
  logic [31:0] wb_data;        // value for the register file

  modport execute (output alu_result, input wb_data);
  modport result (input alu_result, data_readdata, output wb_data);
endinterface

//--- logic/mips_decoder.sv
`timescale 1ns/1ps

module mips_decoder (
  input logic [31:0] instr,
  mips_ctrl_if.decode ctrl
);
  import mips_pkg::*;

  opcode_e op;
  funct_e  fn;

  assign op = opcode_e'(instr[31:26]);
  assign fn = funct_e'(instr[5:0]);

  always_comb begin
    // defaults make anything unknown a no-op
    ctrl.alu_op       = ALU_ADD;
    ctrl.alu_src_imm  = 1'b0;
    ctrl.imm_zero_ext = 1'b0;
    ctrl.reg_dst_rd   = 1'b0;
    ctrl.reg_write    = 1'b0;
    ctrl.mem_to_reg   = 1'b0;
    ctrl.mem_write    = 1'b0;
    ctrl.mem_read     = 1'b0;
    ctrl.load_kind    = LD_WORD;
    ctrl.branch_eq    = 1'b0;
    ctrl.branch_ne    = 1'b0;
    ctrl.jump         = 1'b0;
    ctrl.jump_reg     = 1'b0;

    case (op)
      OP_SPECIAL: begin
        ctrl.reg_dst_rd = 1'b1;
        ctrl.reg_write  = 1'b1;  // cleared below for jr and unknown funct
        case (fn)
          FN_ADDU: ctrl.alu_op = ALU_ADD;
          FN_SUBU: ctrl.alu_op = ALU_SUB;
          FN_AND:  ctrl.alu_op = ALU_AND;
          FN_OR:   ctrl.alu_op = ALU_OR;
          FN_XOR:  ctrl.alu_op = ALU_XOR;
          FN_SLT:  ctrl.alu_op = ALU_SLT;
          FN_SLTU: ctrl.alu_op = ALU_SLTU;
          FN_JR: begin
            ctrl.reg_write = 1'b0;
            ctrl.jump_reg  = 1'b1;  // pc <= rs
          end
          default: ctrl.reg_write = 1'b0;  // sll nop lands here too
        endcase
      end
      OP_ADDIU: begin
        ctrl.alu_src_imm = 1'b1;  // sign extended imm
        ctrl.reg_write   = 1'b1;
      end
      OP_ANDI: begin
        ctrl.alu_op       = ALU_AND;
        ctrl.alu_src_imm  = 1'b1;
        ctrl.imm_zero_ext = 1'b1;
        ctrl.reg_write    = 1'b1;
      end
      OP_ORI: begin
        ctrl.alu_op       = ALU_OR;
        ctrl.alu_src_imm  = 1'b1;
        ctrl.imm_zero_ext = 1'b1;
        ctrl.reg_write    = 1'b1;
      end
      OP_LUI: begin
        ctrl.alu_op      = ALU_LUI;
        ctrl.alu_src_imm = 1'b1;
        ctrl.reg_write   = 1'b1;
      end
      OP_LW, OP_LB, OP_LBU: begin
        // address is rs + simm
        ctrl.alu_src_imm = 1'b1;
        ctrl.reg_write   = 1'b1;
        ctrl.mem_to_reg  = 1'b1;
        ctrl.mem_read    = 1'b1;
        ctrl.load_kind   = (op == OP_LW) ? LD_WORD :
                           (op == OP_LB) ? LD_BYTE : LD_BYTE_U;
      end
      OP_SW: begin
        ctrl.alu_src_imm = 1'b1;
        ctrl.mem_write   = 1'b1;  // rt goes out as write data
      end
      OP_BEQ: ctrl.branch_eq = 1'b1;
      OP_BNE: ctrl.branch_ne = 1'b1;
      OP_J:   ctrl.jump      = 1'b1;
      default: ;  // unknown opcode, nothing happens
    endcase
  end

endmodule

//--- logic/mips_execute.sv
`timescale 1ns/1ps
`include "mips_params.svh"

module mips_execute (
  input  logic                clk,
  input  logic                rst_n,
  input  logic                clk_enable,
  input  logic [31:0]         instr,
  mips_ctrl_if.execute        ctrl,
  mips_wb_if.execute          wb,
  output logic [31:0]         pc,
  output logic                active,
  output logic [31:0]         mem_addr,
  output logic [31:0]         mem_wdata,
  output logic                mem_write,
  output logic                mem_read,
  output logic [31:0]         reg_v0
);
  import mips_pkg::*;

  logic [31:0] regs [0:31];  // regs[0] never written

  logic [4:0]  rs, rt, rd, dest;
  logic [15:0] imm;
  logic [31:0] rs_val, rt_val;
  logic [31:0] imm_ext, src_b, alu_y;
  logic [31:0] pc_plus4, branch_target, jump_target, next_pc;
  logic        regs_eq, take_branch;
  logic        advance;  // this edge retires an instruction

  // instruction fields
  assign rs   = instr[25:21];
  assign rt   = instr[20:16];
  assign rd   = instr[15:11];
  assign imm  = instr[15:0];
  assign dest = ctrl.reg_dst_rd ? rd : rt;

  assign rs_val = regs[rs];
  assign rt_val = regs[rt];

  // operand b
  assign imm_ext = ctrl.imm_zero_ext ? {16'h0000, imm} : {{16{imm[15]}}, imm};
  assign src_b   = ctrl.alu_src_imm ? imm_ext : rt_val;

  always_comb begin
    case (ctrl.alu_op)
      ALU_ADD:  alu_y = rs_val + src_b;
      ALU_SUB:  alu_y = rs_val - src_b;
      ALU_AND:  alu_y = rs_val & src_b;
      ALU_OR:   alu_y = rs_val | src_b;
      ALU_XOR:  alu_y = rs_val ^ src_b;
      ALU_SLT:  alu_y = {31'b0, $signed(rs_val) < $signed(src_b)};
      ALU_SLTU: alu_y = {31'b0, rs_val < src_b};
      ALU_LUI:  alu_y = {src_b[15:0], 16'h0000};
      default:  alu_y = 32'h0;
    endcase
  end

  assign wb.alu_result = alu_y;

  // next pc, no delay slot
  assign pc_plus4      = pc + 32'd4;
  assign branch_target = pc_plus4 + {{14{imm[15]}}, imm, 2'b00};
  assign jump_target   = {pc_plus4[31:28], instr[25:0], 2'b00};
  assign regs_eq       = (rs_val == rt_val);
  assign take_branch   = (ctrl.branch_eq & regs_eq) | (ctrl.branch_ne & ~regs_eq);

  always_comb begin
    if (ctrl.jump_reg)
      next_pc = rs_val;
    else if (ctrl.jump)
      next_pc = jump_target;
    else if (take_branch)
      next_pc = branch_target;
    else
      next_pc = pc_plus4;
  end

  assign advance = active & clk_enable;

  // pc and run flag
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      pc     <= `MIPS_RESET_VECTOR;
      active <= 1'b1;
    end else if (advance) begin
      pc <= next_pc;
      if (next_pc == `MIPS_HALT_ADDR)
        active <= 1'b0;  // halted until next reset
    end
  end

  // register file, cleared so programs start from a known state
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      for (int i = 0; i < 32; i++)
        regs[i] <= 32'h0;
    end else if (advance && ctrl.reg_write && dest != 5'd0) begin
      regs[dest] <= wb.wb_data;
    end
  end

  // data bus
  assign mem_addr  = alu_y;
  assign mem_wdata = rt_val;                    // full word, sw only
  assign mem_write = ctrl.mem_write & advance;  // one strobe per store
  assign mem_read  = ctrl.mem_read & advance;

  assign reg_v0 = regs[`MIPS_REG_V0];

endmodule

//--- logic/mips_result.sv
`timescale 1ns/1ps

module mips_result (
  mips_ctrl_if.result ctrl,
  mips_wb_if.result   wb
);
  import mips_pkg::*;

  logic [7:0]  lane;      // addressed byte
  logic [31:0] load_val;

  // little endian, lane 0 in bits 7:0
  always_comb begin
    case (wb.alu_result[1:0])
      2'd0:    lane = wb.data_readdata[7:0];
      2'd1:    lane = wb.data_readdata[15:8];
      2'd2:    lane = wb.data_readdata[23:16];
      default: lane = wb.data_readdata[31:24];
    endcase
  end

  always_comb begin
    case (ctrl.load_kind)
      LD_BYTE:   load_val = {{24{lane[7]}}, lane};  // lb
      LD_BYTE_U: load_val = {24'h0, lane};          // lbu
      default:   load_val = wb.data_readdata;       // lw, aligned
    endcase
  end

  // loads write memory data, everything else the alu
  assign wb.wb_data = ctrl.mem_to_reg ? load_val : wb.alu_result;

endmodule

//--- logic/mips_cpu_harvard.sv
`timescale 1ns/1ps

module mips_cpu_harvard (
  input  logic        clk,
  input  logic        rst_n,
  output logic        active,
  output logic [31:0] register_v0,

  input  logic        clk_enable,

  output logic [31:0] instr_address,   // pc of the executing instr
  input  logic [31:0] instr_readdata,  // comb read of instr_address

  output logic [31:0] data_address,    // alu result
  output logic        data_write,
  output logic        data_read,
  output logic [31:0] data_writedata,
  input  logic [31:0] data_readdata
);

  mips_ctrl_if ctrl_if ();
  mips_wb_if   wb_if ();

  // load data enters the writeback path
  assign wb_if.data_readdata = data_readdata;

  mips_decoder u_decoder (
    .instr (instr_readdata),
    .ctrl  (ctrl_if.decode)
  );

  mips_execute u_execute (
    .clk        (clk),
    .rst_n      (rst_n),
    .clk_enable (clk_enable),
    .instr      (instr_readdata),
    .ctrl       (ctrl_if.execute),
    .wb         (wb_if.execute),
    .pc         (instr_address),
    .active     (active),
    .mem_addr   (data_address),
    .mem_wdata  (data_writedata),
    .mem_write  (data_write),
    .mem_read   (data_read),
    .reg_v0     (register_v0)
  );

  mips_result u_result (
    .ctrl (ctrl_if.result),
    .wb   (wb_if.result)
  );

endmodule

//--- dv/tb_clk_gen.sv
`timescale 1ns/1ps

// free running testbench clock
module tb_clk_gen #(
  parameter int HALF_PERIOD = 5  // ns, 10 ns period
) (
  output logic clk
);
  initial begin
    clk = 1'b0;
    forever #(HALF_PERIOD) clk = ~clk;
  end
endmodule

//--- dv/mips_cpu_assert.sv
`timescale 1ns/1ps

// bus and halt properties, bound into the cpu top
module mips_cpu_assert (
  input logic clk,
  input logic rst_n,
  input logic clk_enable,
  input logic active,
  input logic data_write,
  input logic data_read
);
  int fails = 0;  // count of failed properties

  // a single cycle is either a load or a store
  no_dual_strobe: assert property (@(posedge clk) disable iff (!rst_n)
    !(data_write && data_read))
    else begin
      fails++;
      $error("data_write and data_read are high in the same cycle");
    end

  // strobes only while running and enabled
  strobe_gated: assert property (@(posedge clk) disable iff (!rst_n)
    (!active || !clk_enable) |-> !(data_write || data_read))
    else begin
      fails++;
      $error("memory strobe high while halted or stalled");
    end

  // halt is sticky until reset
  halt_sticky: assert property (@(posedge clk) disable iff (!rst_n)
    !active |=> !active)
    else begin
      fails++;
      $error("active rose again without a reset");
    end
endmodule

bind mips_cpu_harvard mips_cpu_assert u_assert (
  .clk        (clk),
  .rst_n      (rst_n),
  .clk_enable (clk_enable),
  .active     (active),
  .data_write (data_write),
  .data_read  (data_read)
);

//--- dv/mips_cpu_tb.sv
`timescale 1ns/1ps
`include "mips_params.svh"

module mips_cpu_tb;
  import mips_pkg::*;

  localparam logic [31:0] RESET_PC = `MIPS_RESET_VECTOR;
  localparam int PROG_LEN   = 40;
  localparam int NUM_PROGS  = 20;
  localparam int MAX_CYCLES = 500;  // per program, well above 40 instrs plus stalls

  logic        clk, rst_n, clk_enable, active, data_write, data_read;
  logic [31:0] register_v0, instr_address, instr_readdata;
  logic [31:0] data_address, data_writedata, data_readdata;

  logic [31:0] imem [0:63];   // program at the reset vector
  logic [31:0] dmem [0:15];   // data region 0x100..0x13f
  logic [31:0] m_dmem [0:15]; // model copy
  logic [31:0] m_regs [0:31];
  logic [31:0] m_pc;
  logic        m_active;
  integer      seed;

  tb_clk_gen u_clk (.clk(clk));

  mips_cpu_harvard DUT (
    .clk(clk), .rst_n(rst_n), .active(active), .register_v0(register_v0),
    .clk_enable(clk_enable),
    .instr_address(instr_address), .instr_readdata(instr_readdata),
    .data_address(data_address), .data_write(data_write), .data_read(data_read),
    .data_writedata(data_writedata), .data_readdata(data_readdata)
  );

  // both memories answer in the same cycle, nop outside the program
  assign instr_readdata = (instr_address[31:8] == RESET_PC[31:8]) ?
                          imem[instr_address[7:2]] : 32'h0;
  assign data_readdata  = (data_address[31:6] == 26'h4) ? dmem[data_address[5:2]] : 32'h0;

  task automatic abort_run(input string why);
    $display("%s", why);
    $display("TESTBENCH FAILED");
    $fatal(1);
  endtask

  task automatic check_eq(input string name, input logic [31:0] got, input logic [31:0] exp);
    if (got !== exp)
      abort_run($sformatf("FAILED %s: got 0x%h, expected 0x%h", name, got, exp));
  endtask

  function automatic int unsigned urand(input int unsigned n);
    urand = $unsigned($random(seed)) % n;
  endfunction

  // random forward-only program, ra cleared first, jr ra last
  task automatic load_program();
    logic [4:0]  rs, rt, rd;
    logic [15:0] imm, wofs, bofs;
    logic [31:0] tgt;
    begin
      for (int k = 0; k < 64; k++)
        imem[k] = 32'h0;
      imem[0] = {OP_ADDIU, 5'd0, `MIPS_REG_RA, 16'h0};
      for (int i = 1; i < PROG_LEN - 1; i++) begin
        rs   = 5'(urand(8));  // regs 0..7 only, ra stays zero
        rt   = 5'(urand(8));
        rd   = 5'(urand(8));
        imm  = 16'($random(seed));
        wofs = 16'h0100 | {10'h0, 4'(urand(16)), 2'b00};  // aligned word
        bofs = 16'h0100 | {10'h0, 6'(urand(64))};         // any byte
        tgt  = RESET_PC + 32'((i + 1 + urand(PROG_LEN - 1 - i)) * 4);
        case (urand(18))
          0:  imem[i] = {OP_SPECIAL, rs, rt, rd, 5'd0, FN_ADDU};
          1:  imem[i] = {OP_SPECIAL, rs, rt, rd, 5'd0, FN_SUBU};
          2:  imem[i] = {OP_SPECIAL, rs, rt, rd, 5'd0, FN_AND};
          3:  imem[i] = {OP_SPECIAL, rs, rt, rd, 5'd0, FN_OR};
          4:  imem[i] = {OP_SPECIAL, rs, rt, rd, 5'd0, FN_XOR};
          5:  imem[i] = {OP_SPECIAL, rs, rt, rd, 5'd0, FN_SLT};
          6:  imem[i] = {OP_SPECIAL, rs, rt, rd, 5'd0, FN_SLTU};
          7:  imem[i] = {OP_ADDIU, rs, rt, imm};
          8:  imem[i] = {OP_ANDI, rs, rt, imm};
          9:  imem[i] = {OP_ORI, rs, rt, imm};
          10: imem[i] = {OP_LUI, 5'd0, rt, imm};
          11: imem[i] = {OP_LW, 5'd0, rt, wofs};  // base is $zero
          12: imem[i] = {OP_LB, 5'd0, rt, bofs};
          13: imem[i] = {OP_LBU, 5'd0, rt, bofs};
          14: imem[i] = {OP_SW, 5'd0, rt, wofs};
          15: imem[i] = {OP_BEQ, rs, rt, 16'((tgt - RESET_PC) / 4 - (i + 1))};
          16: imem[i] = {OP_BNE, rs, rt, 16'((tgt - RESET_PC) / 4 - (i + 1))};
          default: imem[i] = {OP_J, tgt[27:2]};
        endcase
      end
      imem[PROG_LEN - 1] = {OP_SPECIAL, `MIPS_REG_RA, 5'd0, 5'd0, 5'd0, FN_JR};
      for (int k = 0; k < 16; k++) begin
        dmem[k]   = $random(seed);
        m_dmem[k] = dmem[k];
      end
    end
  endtask

  // ISA reference, one instruction per call
  task automatic model_step(output logic wr, output logic rd, output logic [31:0] addr,
                            output logic [31:0] wdata);
    logic [31:0] ins, a, b, simm, nxt, word, sh, wv;
    logic [4:0]  wd;
    logic        we;
    begin
      ins   = imem[m_pc[7:2]];
      a     = m_regs[ins[25:21]];
      b     = m_regs[ins[20:16]];
      simm  = {{16{ins[15]}}, ins[15:0]};
      nxt   = m_pc + 32'd4;  // no delay slot
      addr  = a + simm;
      wdata = b;
      wr    = 1'b0;
      rd    = 1'b0;
      we    = 1'b1;
      wd    = ins[20:16];    // rt unless r-type
      wv    = 32'h0;
      case (ins[31:26])
        OP_SPECIAL: begin
          wd = ins[15:11];
          case (ins[5:0])
            FN_ADDU: wv = a + b;
            FN_SUBU: wv = a - b;
            FN_AND:  wv = a & b;
            FN_OR:   wv = a | b;
            FN_XOR:  wv = a ^ b;
            FN_SLT:  wv = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            FN_SLTU: wv = (a < b) ? 32'd1 : 32'd0;
            FN_JR: begin
              we  = 1'b0;
              nxt = a;
            end
            default: we = 1'b0;
          endcase
        end
        OP_ADDIU: wv = a + simm;
        OP_ANDI:  wv = a & {16'h0, ins[15:0]};
        OP_ORI:   wv = a | {16'h0, ins[15:0]};
        OP_LUI:   wv = {ins[15:0], 16'h0};
        OP_LW, OP_LB, OP_LBU: begin
          rd   = 1'b1;
          word = m_dmem[addr[5:2]];
          sh   = word >> {addr[1:0], 3'b000};  // lane 0 is bits 7:0
          if (ins[31:26] == OP_LW)
            wv = word;
          else if (ins[31:26] == OP_LB)
            wv = {{24{sh[7]}}, sh[7:0]};
          else
            wv = {24'h0, sh[7:0]};
        end
        OP_SW: begin
          we = 1'b0;
          wr = 1'b1;
          m_dmem[addr[5:2]] = b;
        end
        OP_BEQ: begin
          we = 1'b0;
          if (a == b) nxt = nxt + {simm[29:0], 2'b00};
        end
        OP_BNE: begin
          we = 1'b0;
          if (a != b) nxt = nxt + {simm[29:0], 2'b00};
        end
        OP_J: begin
          we  = 1'b0;
          nxt = {nxt[31:28], ins[25:0], 2'b00};
        end
        default: we = 1'b0;
      endcase
      if (we && wd != 5'd0)
        m_regs[wd] = wv;
      m_pc = nxt;
      if (nxt == `MIPS_HALT_ADDR)
        m_active = 1'b0;
    end
  endtask

  task automatic reset_and_load();
    @(posedge clk);
    #1;
    rst_n      = 1'b0;
    clk_enable = 1'b0;
    load_program();
    repeat (5) @(posedge clk);
    #1 rst_n = 1'b1;
    m_pc     = RESET_PC;
    m_active = 1'b1;
    for (int k = 0; k < 32; k++)
      m_regs[k] = 32'h0;
    check_eq("instr_address", instr_address, RESET_PC);  // state right after reset
    check_eq("active", active, 1'b1);
    check_eq("data_write", data_write, 1'b0);
    check_eq("data_read", data_read, 1'b0);
  endtask

  // one pass per cycle, drive at edge+1, sample at edge+4
  task automatic run_program(input int prog);
    logic        ewr, erd, st_pend;
    logic [31:0] eaddr, ewdata, st_addr, st_data;
    int          cycles;
    bit          done;
    begin
      cycles = 0;
      done   = 1'b0;
      while (!done) begin
        if (cycles >= MAX_CYCLES)
          abort_run($sformatf("program %0d did not halt within %0d cycles", prog, MAX_CYCLES));
        clk_enable = (urand(10) != 0);  // stall on about a tenth
        #3;
        if (DUT.u_assert.fails != 0)
          abort_run("a bound assertion on the data bus or the halt flag failed");
        check_eq("active", active, m_active);
        check_eq("instr_address", instr_address, m_pc);
        check_eq("register_v0", register_v0, m_regs[`MIPS_REG_V0]);
        if (!active) begin
          done = 1'b1;
        end else if (clk_enable) begin
          model_step(ewr, erd, eaddr, ewdata);
          check_eq("data_write", data_write, ewr);
          check_eq("data_read", data_read, erd);
          if (ewr || erd)
            check_eq("data_address", data_address, eaddr);
          if (ewr)
            check_eq("data_writedata", data_writedata, ewdata);
        end else begin
          check_eq("data_write", data_write, 1'b0);  // stalled
          check_eq("data_read", data_read, 1'b0);
        end
        st_pend = data_write;
        st_addr = data_address;
        st_data = data_writedata;
        if (!done) begin
          @(posedge clk);
          if (st_pend && st_addr[31:6] == 26'h4)
            dmem[st_addr[5:2]] = st_data;  // store lands on the edge
          #1;
          cycles++;
        end
      end
    end
  endtask

  initial begin
    seed       = 32'hfa08_e4c6;
    rst_n      = 1'b0;
    clk_enable = 1'b0;
    for (int p = 0; p < NUM_PROGS; p++) begin
      reset_and_load();
      run_program(p);
      for (int k = 0; k < 16; k++)
        check_eq($sformatf("dmem[%0d]", k), dmem[k], m_dmem[k]);
    end
    if (DUT.u_assert.fails != 0) begin
      abort_run("a bound assertion failed during the run");
    end else begin
      $display("TESTBENCH PASSED");
      $finish;
    end
  end

endmodule

//--- files.f
+incdir+include
logic/mips_pkg.sv
logic/mips_ctrl_if.sv
logic/mips_decoder.sv
logic/mips_execute.sv
logic/mips_result.sv
logic/mips_cpu_harvard.sv
dv/tb_clk_gen.sv
dv/mips_cpu_assert.sv
dv/mips_cpu_tb.sv
